//--- src/cfu_settings.svh
// --------------------
// Control-flow unit build settings
// Widths and writeback queue sizing
// --------------------

`ifndef CFU_SETTINGS_SVH
`define CFU_SETTINGS_SVH

// Data and PC width
`define CFU_XLEN 32

// Sequence number width from 3 to 9
`define CFU_SEQ_BITS 5

// Architectural register address width
`define CFU_REG_BITS 5

// Writeback queue entries as a power of two
`define CFU_WBQ_DEPTH 2
`define CFU_WBQ_IDX_BITS $clog2(`CFU_WBQ_DEPTH)

`endif

//--- src/cfu_pkg.sv
// --------------------
// Control-flow unit types
// Opcode encoding and writeback entry layout
// --------------------

`include "cfu_settings.svh"

package cfu_pkg;

  // --------------------
  // Micro-op opcodes
  // --------------------

  // Only the control-flow subset handled here
  typedef enum logic [1:0] {
    UOP_JAL  = 2'd0,
    UOP_JALR = 2'd1,
    UOP_BNE  = 2'd2
  } cfu_uop_e;

  // --------------------
  // Writeback message
  // --------------------

  // Waddr and wdata only meaningful with wen set
  typedef struct packed {
    logic [`CFU_XLEN-1:0]     pc;
    logic [`CFU_SEQ_BITS-1:0] seq_num;
    logic [`CFU_REG_BITS-1:0] waddr;
    logic [`CFU_XLEN-1:0]     wdata;
    logic                     wen;
  } cfu_wb_entry_t;

endpackage

//--- src/cfu_if.sv
// --------------------
// Issue and writeback channels
// Val/rdy bundles between the unit's blocks
// --------------------

`timescale 1ns/100ps

`include "cfu_settings.svh"

// --------------------
// Dispatch to execute
// --------------------

interface cfu_issue_if;

  logic                     val;
  logic                     rdy;
  logic [`CFU_XLEN-1:0]     pc;
  logic [`CFU_SEQ_BITS-1:0] seq_num;
  logic [`CFU_XLEN-1:0]     op1;
  logic [`CFU_XLEN-1:0]     op2;
  logic [`CFU_XLEN-1:0]     imm;
  logic [`CFU_REG_BITS-1:0] waddr;
  cfu_pkg::cfu_uop_e        uop;

  // Handshake side plus fields for the squash record
  modport ctrl (
    input  val,
    output rdy,
    input  pc,
    input  seq_num
  );

  // Datapath side reads all payload fields
  modport dp (
    input pc,
    input seq_num,
    input op1,
    input op2,
    input imm,
    input waddr,
    input uop
  );

endinterface

// --------------------
// Execute to writeback
// --------------------

interface cfu_wb_if;

  logic                    val;
  logic                    rdy;
  cfu_pkg::cfu_wb_entry_t  entry;

  // Handshake owner
  modport ctrl (
    output val,
    input  rdy
  );

  // Payload comes straight from queue storage
  modport queue (
    output entry
  );

endinterface

//--- src/cfu_ctrl.sv
// --------------------
// Control-flow unit control
// Handshakes, queue pointers and occupancy,
// and the one-cycle squash notice
// --------------------

`timescale 1ns/100ps

`include "cfu_settings.svh"

module cfu_ctrl (
  input  logic                        clk,
  input  logic                        arst_n,
  cfu_issue_if.ctrl                   issue,
  cfu_wb_if.ctrl                      wb,
  input  logic                        redirect,
  input  logic [`CFU_XLEN-1:0]        target,
  output logic                        wr_en,
  output logic [`CFU_WBQ_IDX_BITS-1:0] wr_idx,
  output logic [`CFU_WBQ_IDX_BITS-1:0] rd_idx,
  output logic                        sq_val,
  output logic [`CFU_SEQ_BITS-1:0]    sq_seq_num,
  output logic [`CFU_XLEN-1:0]        sq_target
);

  // --------------------
  // Queue state
  // --------------------

  // One extra bit so a full queue is representable
  logic [`CFU_WBQ_IDX_BITS:0]   count;
  logic [`CFU_WBQ_IDX_BITS-1:0] wr_ptr;
  logic [`CFU_WBQ_IDX_BITS-1:0] rd_ptr;
  logic                         enq;
  logic                         deq;

  // Room left for another micro-op
  assign issue.rdy = (count < (`CFU_WBQ_IDX_BITS+1)'(`CFU_WBQ_DEPTH));

  // Head valid whenever anything is queued
  assign wb.val = (count != '0);

  // Transfers on each side
  assign enq = issue.val && issue.rdy;
  assign deq = wb.val && wb.rdy;

  // Storage write strobe and addresses
  assign wr_en  = enq;
  assign wr_idx = wr_ptr;
  assign rd_idx = rd_ptr;

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy holds on simultaneous enq and deq
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // Squash notice
  // --------------------

  // One-cycle pulse with no back-pressure from the consumer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sq_val <= 1'b0;
    end else begin
      sq_val <= enq && redirect;
    end
  end

  // Record payload captured with the pulse
  always_ff @(posedge clk) begin
    if (enq && redirect) begin
      sq_seq_num <= issue.seq_num;
      sq_target  <= target;
    end
  end

endmodule

//--- src/cfu_target.sv
// --------------------
// Control-flow target generation
// Jump/branch target and fall-through PC
// --------------------

`timescale 1ns/100ps

`include "cfu_settings.svh"

module cfu_target (
  cfu_issue_if.dp                 issue,
  output logic [`CFU_XLEN-1:0]    target,
  output logic [`CFU_XLEN-1:0]    fall_through
);

  logic [`CFU_XLEN-1:0] pc_rel;
  logic [`CFU_XLEN-1:0] reg_rel;

  // PC-relative for JAL and BNE
  assign pc_rel = issue.pc + issue.imm;

  // Register-relative for JALR
  assign reg_rel = issue.op1 + issue.imm;

  // Link value and what fetch predicted
  assign fall_through = issue.pc + `CFU_XLEN'd4;

  // Pick by opcode
  always_comb begin
    case (issue.uop)
      cfu_pkg::UOP_JALR: begin
        // Low bit dropped per the ISA
        target = {reg_rel[`CFU_XLEN-1:1], 1'b0};
      end
      cfu_pkg::UOP_JAL,
      cfu_pkg::UOP_BNE: begin
        target = pc_rel;
      end
      default: begin
        target = pc_rel;
      end
    endcase
  end

endmodule

//--- src/cfu_cond.sv
// --------------------
// Control-flow condition and writeback build
// Taken/redirect decision per opcode
// --------------------

`timescale 1ns/100ps

`include "cfu_settings.svh"

module cfu_cond (
  cfu_issue_if.dp                 issue,
  input  logic [`CFU_XLEN-1:0]    target,
  input  logic [`CFU_XLEN-1:0]    fall_through,
  output logic                    redirect,
  output cfu_pkg::cfu_wb_entry_t  entry
);

  logic ne;
  logic is_jump;
  logic taken;

  // BNE compare
  assign ne = (issue.op1 != issue.op2);

  // Unconditional jumps also write the link
  assign is_jump = (issue.uop == cfu_pkg::UOP_JAL) || (issue.uop == cfu_pkg::UOP_JALR);

  always_comb begin
    case (issue.uop)
      cfu_pkg::UOP_JAL,
      cfu_pkg::UOP_JALR: taken = 1'b1;
      cfu_pkg::UOP_BNE:  taken = ne;
      default:           taken = 1'b0;
    endcase
  end

  // Fetch assumed PC+4, so only a different target redirects
  assign redirect = taken && (target != fall_through);

  // Writeback payload
  assign entry.pc      = issue.pc;
  assign entry.seq_num = issue.seq_num;
  assign entry.waddr   = issue.waddr;
  assign entry.wdata   = fall_through;
  assign entry.wen     = is_jump;

endmodule

//--- src/cfu_wb_queue.sv
// --------------------
// Writeback queue storage
// Entry array indexed by control's pointers
// --------------------

`timescale 1ns/100ps

`include "cfu_settings.svh"

module cfu_wb_queue (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         wr_en,
  input  logic [`CFU_WBQ_IDX_BITS-1:0] wr_idx,
  input  logic [`CFU_WBQ_IDX_BITS-1:0] rd_idx,
  input  cfu_pkg::cfu_wb_entry_t       entry_in,
  cfu_wb_if.queue                      wb
);

  // --------------------
  // Storage
  // --------------------

  cfu_pkg::cfu_wb_entry_t mem [`CFU_WBQ_DEPTH];

  // Write on each accepted micro-op
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CFU_WBQ_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_idx] <= entry_in;
    end
  end

  // --------------------
  // Head
  // --------------------

  // Head entry straight to the writeback side
  // Stays put while w_rdy is low since rd_idx holds
  assign wb.entry = mem[rd_idx];

endmodule

//--- src/cfu_top.sv
// --------------------
// Control-flow execute unit
// JAL, JALR and BNE resolution with writeback
// queue and squash notice
// --------------------

`timescale 1ns/100ps

`include "cfu_settings.svh"

module cfu_top (
  input  logic                     clk,
  input  logic                     arst_n,

  // Dispatch
  input  logic                     d_val,
  output logic                     d_rdy,
  input  logic [`CFU_XLEN-1:0]     d_pc,
  input  logic [`CFU_SEQ_BITS-1:0] d_seq_num,
  input  logic [`CFU_XLEN-1:0]     d_op1,
  input  logic [`CFU_XLEN-1:0]     d_op2,
  input  logic [`CFU_XLEN-1:0]     d_imm,
  input  logic [`CFU_REG_BITS-1:0] d_waddr,
  input  cfu_pkg::cfu_uop_e        d_uop,

  // Writeback
  output logic                     w_val,
  input  logic                     w_rdy,
  output logic [`CFU_XLEN-1:0]     w_pc,
  output logic [`CFU_SEQ_BITS-1:0] w_seq_num,
  output logic [`CFU_REG_BITS-1:0] w_waddr,
  output logic [`CFU_XLEN-1:0]     w_wdata,
  output logic                     w_wen,

  // Squash notice
  output logic                     sq_val,
  output logic [`CFU_SEQ_BITS-1:0] sq_seq_num,
  output logic [`CFU_XLEN-1:0]     sq_target
);

  // --------------------
  // Channels
  // --------------------

  cfu_issue_if issue_if ();
  cfu_wb_if    wb_if ();

  // Dispatch ports onto the issue bundle
  assign issue_if.val     = d_val;
  assign issue_if.pc      = d_pc;
  assign issue_if.seq_num = d_seq_num;
  assign issue_if.op1     = d_op1;
  assign issue_if.op2     = d_op2;
  assign issue_if.imm     = d_imm;
  assign issue_if.waddr   = d_waddr;
  assign issue_if.uop     = d_uop;
  assign d_rdy            = issue_if.rdy;

  // Writeback bundle out to the ports
  assign wb_if.rdy = w_rdy;
  assign w_val     = wb_if.val;
  assign w_pc      = wb_if.entry.pc;
  assign w_seq_num = wb_if.entry.seq_num;
  assign w_waddr   = wb_if.entry.waddr;
  assign w_wdata   = wb_if.entry.wdata;
  assign w_wen     = wb_if.entry.wen;

  // --------------------
  // Blocks
  // --------------------

  logic [`CFU_XLEN-1:0]         target;
  logic [`CFU_XLEN-1:0]         fall_through;
  logic                         redirect;
  cfu_pkg::cfu_wb_entry_t       entry;
  logic                         wr_en;
  logic [`CFU_WBQ_IDX_BITS-1:0] wr_idx;
  logic [`CFU_WBQ_IDX_BITS-1:0] rd_idx;

  cfu_target u_target (
    .issue        (issue_if),
    .target       (target),
    .fall_through (fall_through)
  );

  cfu_cond u_cond (
    .issue        (issue_if),
    .target       (target),
    .fall_through (fall_through),
    .redirect     (redirect),
    .entry        (entry)
  );

  cfu_ctrl u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .issue      (issue_if),
    .wb         (wb_if),
    .redirect   (redirect),
    .target     (target),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .rd_idx     (rd_idx),
    .sq_val     (sq_val),
    .sq_seq_num (sq_seq_num),
    .sq_target  (sq_target)
  );

  cfu_wb_queue u_wb_queue (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .rd_idx   (rd_idx),
    .entry_in (entry),
    .wb       (wb_if)
  );

endmodule

//--- tb/cfu_tb.sv
// --------------------
// Control-flow unit testbench
// Directed JAL/JALR/BNE checks, back-pressure
// and a seeded random run against a rule model
// --------------------

`timescale 1ns/100ps

`include "cfu_settings.svh"

module cfu_tb;

  localparam int XLEN    = `CFU_XLEN;
  localparam int SEQ     = `CFU_SEQ_BITS;
  localparam int REG     = `CFU_REG_BITS;
  localparam int DEPTH   = `CFU_WBQ_DEPTH;
  localparam int TIMEOUT = 100;

  // Expected writeback message
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [SEQ-1:0]  seq;
    logic [REG-1:0]  waddr;
    logic [XLEN-1:0] wdata;
    logic            wen;
  } wb_exp_t;

  // One squash notice
  typedef struct packed {
    logic [SEQ-1:0]  seq;
    logic [XLEN-1:0] target;
  } sq_rec_t;

  logic              clk;
  logic              arst_n;
  logic              d_val;
  logic              d_rdy;
  logic [XLEN-1:0]   d_pc;
  logic [SEQ-1:0]    d_seq_num;
  logic [XLEN-1:0]   d_op1;
  logic [XLEN-1:0]   d_op2;
  logic [XLEN-1:0]   d_imm;
  logic [REG-1:0]    d_waddr;
  cfu_pkg::cfu_uop_e d_uop;
  logic              w_val;
  logic              w_rdy;
  logic [XLEN-1:0]   w_pc;
  logic [SEQ-1:0]    w_seq_num;
  logic [REG-1:0]    w_waddr;
  logic [XLEN-1:0]   w_wdata;
  logic              w_wen;
  logic              sq_val;
  logic [SEQ-1:0]    sq_seq_num;
  logic [XLEN-1:0]   sq_target;

  wb_exp_t exp_wb[$];
  sq_rec_t sq_exp[$];
  sq_rec_t sq_seen[$];
  int      sq_done;
  int      mismatch_count;
  int      fail_count;
  logic    random_done;

  cfu_top i_dut (.*);

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Squash monitor records each pulse
  always @(negedge clk) begin
    if (arst_n && sq_val) begin
      sq_seen.push_back({sq_seq_num, sq_target});
    end
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Rule model for target, link, wen and redirect per opcode
  function automatic void predict(input logic [XLEN-1:0] pc, input logic [SEQ-1:0] seq,
                                  input logic [XLEN-1:0] op1, input logic [XLEN-1:0] op2,
                                  input logic [XLEN-1:0] imm, input logic [REG-1:0] waddr,
                                  input cfu_pkg::cfu_uop_e uop);
    logic [XLEN-1:0] tgt;
    logic            taken;
    wb_exp_t         e;
    if (uop == cfu_pkg::UOP_JALR) begin
      tgt = (op1 + imm) & ~32'd1;
    end else begin
      tgt = pc + imm;
    end
    taken   = (uop == cfu_pkg::UOP_BNE) ? (op1 != op2) : 1'b1;
    e.pc    = pc;
    e.seq   = seq;
    e.waddr = waddr;
    e.wdata = pc + 32'd4;
    e.wen   = (uop != cfu_pkg::UOP_BNE);
    exp_wb.push_back(e);
    // Fetch assumed pc+4
    if (taken && tgt != pc + 32'd4) begin
      sq_exp.push_back({seq, tgt});
    end
  endfunction

  // Offer one micro-op, hold until accepted
  task automatic issue(input logic [XLEN-1:0] pc, input logic [SEQ-1:0] seq,
                       input logic [XLEN-1:0] op1, input logic [XLEN-1:0] op2,
                       input logic [XLEN-1:0] imm, input logic [REG-1:0] waddr,
                       input cfu_pkg::cfu_uop_e uop);
    int   waited;
    logic accepted;
    d_val     = 1'b1;
    d_pc      = pc;
    d_seq_num = seq;
    d_op1     = op1;
    d_op2     = op2;
    d_imm     = imm;
    d_waddr   = waddr;
    d_uop     = uop;
    waited    = 0;
    @(negedge clk);
    while (!d_rdy && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    accepted = d_rdy;
    if (!accepted) begin
      fail_count++;
      $display("Dispatch never ready for seq_num 0x%0h", seq);
    end
    @(posedge clk);
    #2;
    d_val = 1'b0;
    if (accepted) begin
      predict(pc, seq, op1, op2, imm, waddr, uop);
    end
  endtask

  // Wait for one writeback transfer and check it
  task automatic expect_wb();
    int      waited;
    wb_exp_t e;
    waited = 0;
    @(negedge clk);
    while (!(w_val && w_rdy) && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!(w_val && w_rdy)) begin
      fail_count++;
      $display("No writeback arrived in time");
    end else if (exp_wb.size() == 0) begin
      fail_count++;
      $display("Writeback with seq_num 0x%0h that was never issued", w_seq_num);
    end else begin
      e = exp_wb.pop_front();
      check("w_pc", w_pc, e.pc);
      check("w_seq_num", 32'(w_seq_num), 32'(e.seq));
      check("w_wen", 32'(w_wen), 32'(e.wen));
      // Address and data only matter for jumps
      if (e.wen) begin
        check("w_waddr", 32'(w_waddr), 32'(e.waddr));
        check("w_wdata", w_wdata, e.wdata);
      end
    end
    @(posedge clk);
    #2;
  endtask

  // Seen squashes against the model in order
  task automatic compare_squashes();
    repeat (2) @(negedge clk);
    if (sq_seen.size() != sq_exp.size()) begin
      fail_count++;
      $display("Saw %0d squashes, expected %0d", sq_seen.size(), sq_exp.size());
    end
    while (sq_done < sq_seen.size() && sq_done < sq_exp.size()) begin
      check("sq_seq_num", 32'(sq_seen[sq_done].seq), 32'(sq_exp[sq_done].seq));
      check("sq_target", sq_seen[sq_done].target, sq_exp[sq_done].target);
      sq_done++;
    end
    @(posedge clk);
    #2;
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset();
    check("d_rdy", 32'(d_rdy), 32'd1);
    check("w_val", 32'(w_val), 32'd0);
    check("sq_val", 32'(sq_val), 32'd0);
  endtask

  task automatic test_jal();
    issue(32'h1000, SEQ'(1), '0, '0, 32'h40, REG'(1), cfu_pkg::UOP_JAL);
    expect_wb();
    // Jump to pc+4 links but never redirects
    issue(32'h2000, SEQ'(2), '0, '0, 32'h4, REG'(2), cfu_pkg::UOP_JAL);
    expect_wb();
    compare_squashes();
  endtask

  task automatic test_jalr();
    // Odd sum so the low bit must drop
    issue(32'h3000, SEQ'(3), 32'h5001, '0, 32'h10, REG'(3), cfu_pkg::UOP_JALR);
    expect_wb();
    compare_squashes();
  endtask

  task automatic test_bne();
    issue(32'h4000, SEQ'(4), 32'd5, 32'd6, 32'hFFFF_FFF8, REG'(4), cfu_pkg::UOP_BNE);
    expect_wb();
    issue(32'h4100, SEQ'(5), 32'd7, 32'd7, 32'h20, REG'(5), cfu_pkg::UOP_BNE);
    expect_wb();
    compare_squashes();
  endtask

  task automatic test_backpressure();
    w_rdy = 1'b0;
    fork
      begin
        // One more than fits
        for (int i = 0; i <= DEPTH; i++) begin
          issue(32'h5000 + 32'(i * 16), SEQ'(8 + i), '0, '0, 32'h100, REG'(i + 1),
                cfu_pkg::UOP_JAL);
        end
      end
      begin
        repeat (DEPTH + 2) @(posedge clk);
        // Full queue with the head parked
        repeat (2) begin
          @(negedge clk);
          check("d_rdy", 32'(d_rdy), 32'd0);
          check("w_val", 32'(w_val), 32'd1);
          check("w_seq_num", 32'(w_seq_num), 32'd8);
        end
        check("squashes under stall", 32'(sq_seen.size() - sq_done), 32'(DEPTH));
        @(posedge clk);
        #2;
        w_rdy = 1'b1;
        repeat (DEPTH + 1) expect_wb();
      end
    join
    compare_squashes();
  endtask

  task automatic test_random();
    cfu_pkg::cfu_uop_e uop;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   imm;
    random_done = 1'b0;
    fork
      begin
        for (int n = 0; n < 40; n++) begin
          repeat ($urandom % 3) begin
            @(posedge clk);
            #2;
          end
          uop = cfu_pkg::cfu_uop_e'(2'($urandom % 3));
          op1 = $urandom;
          op2 = ($urandom % 2 == 0) ? op1 : $urandom;
          // Small word offsets so pc+4 shows up now and then
          imm = 32'($urandom % 16) * 32'd4 - 32'd24;
          if (uop == cfu_pkg::UOP_JALR) begin
            imm = imm + 32'($urandom % 2);
          end
          issue($urandom & 32'hFFFF_FFFC, SEQ'(n), op1, op2, imm, REG'($urandom), uop);
        end
      end
      begin
        repeat (40) expect_wb();
        random_done = 1'b1;
      end
      begin
        // Writeback stalls on about a third of cycles
        while (!random_done) begin
          @(posedge clk);
          #2;
          w_rdy = ($urandom % 3) != 0;
        end
        w_rdy = 1'b1;
      end
    join
    compare_squashes();
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    void'($urandom(17282));
    arst_n         = 1'b0;
    d_val          = 1'b0;
    d_pc           = '0;
    d_seq_num      = '0;
    d_op1          = '0;
    d_op2          = '0;
    d_imm          = '0;
    d_waddr        = '0;
    d_uop          = cfu_pkg::UOP_JAL;
    w_rdy          = 1'b1;
    sq_done        = 0;
    mismatch_count = 0;
    fail_count     = 0;
    random_done    = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;

    test_reset();
    test_jal();
    test_jalr();
    test_bne();
    test_backpressure();
    test_random();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- cfu_top.f
+incdir+src
src/cfu_pkg.sv
src/cfu_if.sv
src/cfu_ctrl.sv
src/cfu_target.sv
src/cfu_cond.sv
src/cfu_wb_queue.sv
src/cfu_top.sv
tb/cfu_tb.sv

//--- Makefile
# Verilator flow for the control-flow execute unit

TOP   := cfu_tb
FLIST := cfu_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f $(FLIST) --top-module $(TOP) -o cfu_sim
	./obj_dir/cfu_sim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
